//--- common/lsq_macros.svh
`ifndef LSQ_MACROS_SVH
`define LSQ_MACROS_SVH

// queue size
`define LQ_DEPTH 16

// pipeline port counts
`define LDU_NUM 2
`define STU_NUM 2

// max loads retired per cycle
`define COMMIT_WIDTH 2

// physical address width
`define PALEN 32

// age index widths, wrap flag not included
`define ROB_W 5
`define SQ_W 4

`endif

//--- common/lsq_pkg.sv
`include "lsq_macros.svh"

package lsq_pkg;

    localparam int AGE_IDX_W = (`ROB_W > `SQ_W) ? `ROB_W : `SQ_W;
    localparam int LQ_IDX_W  = $clog2(`LQ_DEPTH);
    localparam int LQ_CNT_W  = $clog2(`LQ_DEPTH + 1);
    localparam int CMT_CNT_W = $clog2(`COMMIT_WIDTH + 1);

    // shared by rob and store queue ages
    typedef struct packed {
        logic                 flag;
        logic [AGE_IDX_W-1:0] idx;
    } age_t;

    typedef logic [LQ_IDX_W-1:0] lq_idx_t;

    typedef struct packed {
        logic              vld;
        lq_idx_t           lq_idx;
        age_t              sq_idx;
        logic [`PALEN-1:0] paddr;
        logic [7:0]        mask;
        age_t              rob_idx;
        logic [31:0]       pc;
    } lq_wr_t;

    typedef struct packed {
        age_t              sq_idx;
        logic [`PALEN-1:0] paddr;
        logic [7:0]        mask;
        age_t              rob_idx;
        logic [31:0]       pc;
    } lq_payload_t;

    typedef struct packed {
        logic              vld;
        age_t              sq_idx;
        logic [`PALEN-1:0] paddr;
        logic [7:0]        mask;
    } st_chk_t;

    typedef struct packed {
        logic        vld;
        age_t        rob_idx;
        logic [31:0] pc;
    } lq_vio_t;

    // same lap: smaller index is older; across a wrap the larger one is
    function automatic logic older_than(age_t a, age_t b);
        if (a.flag == b.flag) begin
            return a.idx < b.idx;
        end
        return a.idx > b.idx;
    endfunction

endpackage

//--- rtl/oldest_select.sv
`timescale 1ns/100ps

module oldest_select
    import lsq_pkg::*;
#(
    parameter int  WIDTH     = 4,
    parameter type payload_t = logic
) (
    input  logic [WIDTH-1:0] i_vld,
    input  age_t             i_age     [WIDTH],
    input  payload_t         i_payload [WIDTH],
    output logic             o_vld,
    output age_t             o_age,
    output payload_t         o_payload
);

    // heap layout, leaves padded up to a power of two
    localparam int LEAVES = 1 << $clog2(WIDTH);
    localparam int NODES  = 2 * LEAVES - 1;

    logic     node_vld     [NODES];
    age_t     node_age     [NODES];
    payload_t node_payload [NODES];

    for (genvar n = 0; n < LEAVES; n++) begin : gen_leaf
        if (n < WIDTH) begin : gen_used
            assign node_vld[LEAVES-1+n]     = i_vld[n];
            assign node_age[LEAVES-1+n]     = i_age[n];
            assign node_payload[LEAVES-1+n] = i_payload[n];
        end else begin : gen_pad
            assign node_vld[LEAVES-1+n]     = 1'b0;
            assign node_age[LEAVES-1+n]     = '0;
            assign node_payload[LEAVES-1+n] = '0;
        end
    end

    for (genvar n = 0; n < LEAVES - 1; n++) begin : gen_node
        logic take_right;

        // left wins ties and whenever right is invalid
        assign take_right = node_vld[2*n+2] &&
            (!node_vld[2*n+1] || older_than(node_age[2*n+2], node_age[2*n+1]));

        assign node_vld[n]     = node_vld[2*n+1] || node_vld[2*n+2];
        assign node_age[n]     = take_right ? node_age[2*n+2] : node_age[2*n+1];
        assign node_payload[n] = take_right ? node_payload[2*n+2] : node_payload[2*n+1];
    end

    assign o_vld     = node_vld[0];
    assign o_age     = node_age[0];
    assign o_payload = node_payload[0];

endmodule

//--- load_queue/lq_ctrl.sv
`timescale 1ns/100ps
`include "lsq_macros.svh"

module lq_ctrl
    import lsq_pkg::*;
(
    input  logic                 clk,
    input  logic                 i_rst,
    input  logic                 i_flush,
    input  lq_wr_t               i_ld_wr [`LDU_NUM],
    input  logic [CMT_CNT_W-1:0] i_commit_cnt,
    output logic [`LDU_NUM-1:0]  o_wr_en,
    output lq_idx_t              o_wr_idx [`LDU_NUM],
    output logic [`LQ_DEPTH-1:0] o_nxt_vld,
    output logic [LQ_CNT_W-1:0]  o_lq_used
);

    localparam logic [LQ_IDX_W:0] DEPTH_EXT = (LQ_IDX_W + 1)'(`LQ_DEPTH);

    logic [`LQ_DEPTH-1:0] vld_q;
    lq_idx_t              deq_ptr;
    lq_idx_t              deq_ptr_nxt;
    logic [`LQ_DEPTH-1:0] retire_mask;

    // pointer add with modulo-depth wrap
    function automatic lq_idx_t wrap_add(lq_idx_t base, logic [LQ_IDX_W:0] ofs);
        logic [LQ_IDX_W:0] sum;
        sum = {1'b0, base} + ofs;
        if (sum >= DEPTH_EXT) begin
            sum = sum - DEPTH_EXT;
        end
        return sum[LQ_IDX_W-1:0];
    endfunction

    always_comb begin
        for (int p = 0; p < `LDU_NUM; p++) begin
            o_wr_en[p]  = i_ld_wr[p].vld;
            o_wr_idx[p] = i_ld_wr[p].lq_idx;
        end
    end

    // loads landing this cycle are already visible to the store check
    always_comb begin
        o_nxt_vld = vld_q;
        for (int p = 0; p < `LDU_NUM; p++) begin
            if (o_wr_en[p]) begin
                o_nxt_vld[o_wr_idx[p]] = 1'b1;
            end
        end
    end

    always_comb begin
        retire_mask = '0;
        for (int k = 0; k < `COMMIT_WIDTH; k++) begin
            if (i_commit_cnt > k) begin
                retire_mask[wrap_add(deq_ptr, (LQ_IDX_W + 1)'(k))] = 1'b1;
            end
        end
        deq_ptr_nxt = wrap_add(deq_ptr, (LQ_IDX_W + 1)'(i_commit_cnt));
    end

    // flush shares the reset clear path
    always_ff @(posedge clk) begin
        if (i_rst || i_flush) begin
            vld_q   <= '0;
            deq_ptr <= '0;
        end else begin
            vld_q   <= o_nxt_vld & ~retire_mask;
            deq_ptr <= deq_ptr_nxt;
        end
    end

    // occupancy
    always_comb begin
        o_lq_used = '0;
        for (int e = 0; e < `LQ_DEPTH; e++) begin
            o_lq_used = o_lq_used + LQ_CNT_W'(vld_q[e]);
        end
    end

endmodule

//--- load_queue/lq_entry_array.sv
`timescale 1ns/100ps
`include "lsq_macros.svh"

module lq_entry_array
    import lsq_pkg::*;
(
    input  logic                clk,
    input  logic [`LDU_NUM-1:0] i_wr_en,
    input  lq_idx_t             i_wr_idx [`LDU_NUM],
    input  lq_wr_t              i_ld_wr [`LDU_NUM],
    output lq_payload_t         o_nxt_payload [`LQ_DEPTH]
);

    lq_payload_t payload_q  [`LQ_DEPTH];
    lq_payload_t wr_payload [`LDU_NUM];

    // strip the port fields off each write
    always_comb begin
        for (int p = 0; p < `LDU_NUM; p++) begin
            wr_payload[p].sq_idx  = i_ld_wr[p].sq_idx;
            wr_payload[p].paddr   = i_ld_wr[p].paddr;
            wr_payload[p].mask    = i_ld_wr[p].mask;
            wr_payload[p].rob_idx = i_ld_wr[p].rob_idx;
            wr_payload[p].pc      = i_ld_wr[p].pc;
        end
    end

    // payload only, entry validity is tracked in lq_ctrl
    always_ff @(posedge clk) begin
        for (int p = 0; p < `LDU_NUM; p++) begin
            if (i_wr_en[p]) begin
                payload_q[i_wr_idx[p]] <= wr_payload[p];
            end
        end
    end

    // stored view overlaid with this cycle's writes
    always_comb begin
        o_nxt_payload = payload_q;
        for (int p = 0; p < `LDU_NUM; p++) begin
            if (i_wr_en[p]) begin
                o_nxt_payload[i_wr_idx[p]] = wr_payload[p];
            end
        end
    end

endmodule

//--- load_queue/lq_vio_check.sv
`timescale 1ns/100ps
`include "lsq_macros.svh"

module lq_vio_check
    import lsq_pkg::*;
(
    input  logic                 clk,
    input  logic                 i_rst,
    input  logic                 i_flush,
    input  st_chk_t              i_st_chk [`STU_NUM],
    input  logic [`LQ_DEPTH-1:0] i_nxt_vld,
    input  lq_payload_t          i_nxt_payload [`LQ_DEPTH],
    output lq_vio_t              o_vio [`STU_NUM]
);

    age_t                 entry_age [`LQ_DEPTH];
    logic [`LQ_DEPTH-1:0] hit [`STU_NUM];

    logic                 sel_vld     [`STU_NUM];
    age_t                 sel_age     [`STU_NUM];
    lq_payload_t          sel_payload [`STU_NUM];

    logic [`STU_NUM-1:0]  vio_vld_q;
    age_t                 vio_rob_q [`STU_NUM];
    logic [31:0]          vio_pc_q  [`STU_NUM];

    always_comb begin
        for (int e = 0; e < `LQ_DEPTH; e++) begin
            entry_age[e] = i_nxt_payload[e].rob_idx;
        end
    end

    // younger load already read bytes that an older store now writes
    always_comb begin
        for (int s = 0; s < `STU_NUM; s++) begin
            for (int e = 0; e < `LQ_DEPTH; e++) begin
                hit[s][e] = i_st_chk[s].vld && i_nxt_vld[e] &&
                    older_than(i_st_chk[s].sq_idx, i_nxt_payload[e].sq_idx) &&
                    (i_st_chk[s].paddr[`PALEN-1:3] == i_nxt_payload[e].paddr[`PALEN-1:3]) &&
                    ((i_st_chk[s].mask & i_nxt_payload[e].mask) != 8'h00);
            end
        end
    end

    for (genvar s = 0; s < `STU_NUM; s++) begin : gen_port
        oldest_select #(
            .WIDTH     (`LQ_DEPTH),
            .payload_t (lq_payload_t)
        ) u_oldest (
            .i_vld     (hit[s]),
            .i_age     (entry_age),
            .i_payload (i_nxt_payload),
            .o_vld     (sel_vld[s]),
            .o_age     (sel_age[s]),
            .o_payload (sel_payload[s])
        );
    end

    always_ff @(posedge clk) begin
        for (int s = 0; s < `STU_NUM; s++) begin
            if (i_rst || i_flush) begin
                vio_vld_q[s] <= 1'b0;
            end else begin
                vio_vld_q[s] <= sel_vld[s];
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int s = 0; s < `STU_NUM; s++) begin
            vio_rob_q[s] <= sel_age[s];
            vio_pc_q[s]  <= sel_payload[s].pc;
        end
    end

    always_comb begin
        for (int s = 0; s < `STU_NUM; s++) begin
            o_vio[s].vld     = vio_vld_q[s];
            o_vio[s].rob_idx = vio_rob_q[s];
            o_vio[s].pc      = vio_pc_q[s];
        end
    end

endmodule

//--- rtl/lsq_top.sv
`timescale 1ns/100ps
`include "lsq_macros.svh"

module lsq_top
    import lsq_pkg::*;
(
    input  logic                 clk,
    input  logic                 i_rst,
    input  lq_wr_t               i_ld_wr  [`LDU_NUM],
    input  st_chk_t              i_st_chk [`STU_NUM],
    input  logic [CMT_CNT_W-1:0] i_commit_cnt,
    input  logic                 i_flush,
    output lq_vio_t              o_vio [`STU_NUM],
    output logic [LQ_CNT_W-1:0]  o_lq_used
);

    logic [`LDU_NUM-1:0]  wr_en;
    lq_idx_t              wr_idx [`LDU_NUM];
    logic [`LQ_DEPTH-1:0] nxt_vld;
    lq_payload_t          nxt_payload [`LQ_DEPTH];

    lq_ctrl u_ctrl (
        .clk          (clk),
        .i_rst        (i_rst),
        .i_flush      (i_flush),
        .i_ld_wr      (i_ld_wr),
        .i_commit_cnt (i_commit_cnt),
        .o_wr_en      (wr_en),
        .o_wr_idx     (wr_idx),
        .o_nxt_vld    (nxt_vld),
        .o_lq_used    (o_lq_used)
    );

    lq_entry_array u_array (
        .clk           (clk),
        .i_wr_en       (wr_en),
        .i_wr_idx      (wr_idx),
        .i_ld_wr       (i_ld_wr),
        .o_nxt_payload (nxt_payload)
    );

    // compares against the write-merged view
    lq_vio_check u_vio (
        .clk           (clk),
        .i_rst         (i_rst),
        .i_flush       (i_flush),
        .i_st_chk      (i_st_chk),
        .i_nxt_vld     (nxt_vld),
        .i_nxt_payload (nxt_payload),
        .o_vio         (o_vio)
    );

endmodule

//--- bench/lsq_properties.sv
`timescale 1ns/100ps
`include "lsq_macros.svh"

module lsq_properties
    import lsq_pkg::*;
(
    input logic                 clk,
    input logic                 i_rst,
    input logic [`LDU_NUM-1:0]  i_wr_en,
    input lq_idx_t              i_wr_idx [`LDU_NUM],
    input logic [`LQ_DEPTH-1:0] i_vld,
    input logic [`LQ_DEPTH-1:0] i_retire_mask,
    input logic [LQ_CNT_W-1:0]  i_lq_used
);

    // a load only lands in a free slot
    for (genvar p = 0; p < `LDU_NUM; p++) begin : gen_wr
        wr_free_slot : assert property (@(posedge clk) disable iff (i_rst)
            i_wr_en[p] |-> !i_vld[i_wr_idx[p]])
            else $error("load port %0d wrote occupied slot %0d", p, i_wr_idx[p]);
    end

    // both load ports never share a slot
    wr_distinct : assert property (@(posedge clk) disable iff (i_rst)
        (i_wr_en[0] && i_wr_en[1]) |-> (i_wr_idx[0] != i_wr_idx[1]))
        else $error("both load ports wrote slot %0d", i_wr_idx[0]);

    // commits walk valid entries only
    commit_valid : assert property (@(posedge clk) disable iff (i_rst)
        (i_retire_mask & ~i_vld) == '0)
        else $error("commit retired empty slots %h", i_retire_mask & ~i_vld);

    // occupancy after the edge stays within the queue
    used_bound : assert property (@(posedge clk) disable iff (i_rst)
        (int'(i_lq_used) + $countones(i_wr_en)) <= (`LQ_DEPTH + $countones(i_retire_mask)))
        else $error("occupancy %0d plus %0d writes above queue depth",
                    i_lq_used, $countones(i_wr_en));

endmodule

bind lq_ctrl lsq_properties u_props (
    .clk           (clk),
    .i_rst         (i_rst),
    .i_wr_en       (o_wr_en),
    .i_wr_idx      (o_wr_idx),
    .i_vld         (vld_q),
    .i_retire_mask (retire_mask),
    .i_lq_used     (o_lq_used)
);

//--- bench/lsq_tb.sv
`timescale 1ns/100ps
`include "lsq_macros.svh"

module lsq_tb
    import lsq_pkg::*;
();

    localparam int RESET_CYCLES = 2;
    localparam int DIR_CYCLES   = 40;
    localparam int RAND_CYCLES  = 400;

    logic                 clk;
    logic                 i_rst;
    logic                 i_flush;
    lq_wr_t               i_ld_wr  [`LDU_NUM];
    st_chk_t              i_st_chk [`STU_NUM];
    logic [CMT_CNT_W-1:0] i_commit_cnt;
    lq_vio_t              o_vio    [`STU_NUM];
    logic [LQ_CNT_W-1:0]  o_lq_used;

    // shadow queue
    logic        mdl_vld [`LQ_DEPTH];
    lq_payload_t mdl_pl  [`LQ_DEPTH];
    int          mdl_deq;
    int          mdl_cnt;
    lq_vio_t     exp_vio [`STU_NUM];

    // stimulus for the next edge
    lq_wr_t      wr [`LDU_NUM];
    st_chk_t     st [`STU_NUM];
    int          cmt;
    logic        fl;
    logic [31:0] rng;
    logic [5:0]  rob_ctr;

    lsq_top UUT (
        .clk          (clk),
        .i_rst        (i_rst),
        .i_ld_wr      (i_ld_wr),
        .i_st_chk     (i_st_chk),
        .i_commit_cnt (i_commit_cnt),
        .i_flush      (i_flush),
        .o_vio        (o_vio),
        .o_lq_used    (o_lq_used)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        #((RESET_CYCLES + DIR_CYCLES + RAND_CYCLES) * 8 * 2);
        $display("timeout: the test sequence did not finish in time");
        $display("STATUS: FAIL");
        $fatal(1, "watchdog expired");
    end

    function automatic logic [31:0] xorshift(logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // wrap flags differ means the index order is reversed
    function automatic logic age_before(age_t a, age_t b);
        if (a.flag != b.flag) begin
            return a.idx > b.idx;
        end
        return a.idx < b.idx;
    endfunction

    function automatic lq_payload_t to_payload(lq_wr_t w);
        lq_payload_t r;
        r.sq_idx  = w.sq_idx;
        r.paddr   = w.paddr;
        r.mask    = w.mask;
        r.rob_idx = w.rob_idx;
        r.pc      = w.pc;
        return r;
    endfunction

    task automatic clear_stim();
        for (int p = 0; p < `LDU_NUM; p++) begin
            wr[p] = '0;
        end
        for (int s = 0; s < `STU_NUM; s++) begin
            st[s] = '0;
        end
        cmt = 0;
        fl  = 1'b0;
    endtask

    task automatic clear_model();
        for (int e = 0; e < `LQ_DEPTH; e++) begin
            mdl_vld[e] = 1'b0;
        end
        for (int s = 0; s < `STU_NUM; s++) begin
            exp_vio[s] = '0;
        end
        mdl_deq = 0;
        mdl_cnt = 0;
    endtask

    task automatic stage_load(int port, int slot, logic [5:0] sq, logic [31:0] addr,
                              logic [7:0] mask, logic [5:0] rob, logic [31:0] pc);
        wr[port].vld     = 1'b1;
        wr[port].lq_idx  = lq_idx_t'(slot);
        wr[port].sq_idx  = sq;
        wr[port].paddr   = addr;
        wr[port].mask    = mask;
        wr[port].rob_idx = rob;
        wr[port].pc      = pc;
    endtask

    task automatic stage_store(int port, logic [5:0] sq, logic [31:0] addr, logic [7:0] mask);
        st[port].vld    = 1'b1;
        st[port].sq_idx = sq;
        st[port].paddr  = addr;
        st[port].mask   = mask;
    endtask

    task automatic report_mismatch(string name, logic [31:0] got, logic [31:0] want);
        $display("ERROR at %0t ns: %s is %0h, expected %0h", $time, name, got, want);
        $display("STATUS: FAIL");
        $fatal(1, "output mismatch");
    endtask

    task automatic check_outputs();
        for (int s = 0; s < `STU_NUM; s++) begin
            assert (o_vio[s].vld === exp_vio[s].vld) else begin
                report_mismatch($sformatf("o_vio[%0d].vld", s),
                                32'(o_vio[s].vld), 32'(exp_vio[s].vld));
            end
            if (exp_vio[s].vld) begin
                assert (o_vio[s].rob_idx === exp_vio[s].rob_idx) else begin
                    report_mismatch($sformatf("o_vio[%0d].rob_idx", s),
                                    32'(o_vio[s].rob_idx), 32'(exp_vio[s].rob_idx));
                end
                assert (o_vio[s].pc === exp_vio[s].pc) else begin
                    report_mismatch($sformatf("o_vio[%0d].pc", s), o_vio[s].pc, exp_vio[s].pc);
                end
            end
        end
        assert (o_lq_used === LQ_CNT_W'(mdl_cnt)) else begin
            report_mismatch("o_lq_used", 32'(o_lq_used), mdl_cnt);
        end
    endtask

    // expected report and queue state after the edge that takes the stimulus
    task automatic model_cycle();
        logic        nv [`LQ_DEPTH];
        lq_payload_t np [`LQ_DEPTH];
        logic        hit;
        for (int e = 0; e < `LQ_DEPTH; e++) begin
            nv[e] = mdl_vld[e];
            np[e] = mdl_pl[e];
        end
        for (int p = 0; p < `LDU_NUM; p++) begin
            if (wr[p].vld) begin
                nv[wr[p].lq_idx] = 1'b1;
                np[wr[p].lq_idx] = to_payload(wr[p]);
            end
        end
        for (int s = 0; s < `STU_NUM; s++) begin
            exp_vio[s] = '0;
            for (int e = 0; e < `LQ_DEPTH; e++) begin
                hit = st[s].vld && nv[e] && age_before(st[s].sq_idx, np[e].sq_idx) &&
                      (st[s].paddr[31:3] == np[e].paddr[31:3]) && |(st[s].mask & np[e].mask);
                if (hit && (!exp_vio[s].vld || age_before(np[e].rob_idx, exp_vio[s].rob_idx))) begin
                    exp_vio[s].vld     = 1'b1;
                    exp_vio[s].rob_idx = np[e].rob_idx;
                    exp_vio[s].pc      = np[e].pc;
                end
            end
        end
        if (fl) begin
            clear_model();
        end else begin
            for (int k = 0; k < cmt; k++) begin
                nv[(mdl_deq + k) % `LQ_DEPTH] = 1'b0;
            end
            mdl_deq = (mdl_deq + cmt) % `LQ_DEPTH;
            mdl_cnt = 0;
            for (int e = 0; e < `LQ_DEPTH; e++) begin
                mdl_vld[e] = nv[e];
                mdl_pl[e]  = np[e];
                mdl_cnt    = mdl_cnt + int'(nv[e]);
            end
        end
    endtask

    // drive on the rising edge, compare mid-cycle
    task automatic step();
        @(posedge clk);
        for (int p = 0; p < `LDU_NUM; p++) begin
            i_ld_wr[p] <= wr[p];
        end
        for (int s = 0; s < `STU_NUM; s++) begin
            i_st_chk[s] <= st[s];
        end
        i_commit_cnt <= CMT_CNT_W'(cmt);
        i_flush      <= fl;
        @(negedge clk);
        check_outputs();
        model_cycle();
        clear_stim();
    endtask

    initial begin
        int nwr;
        i_rst        = 1'b1;
        i_flush      = 1'b0;
        i_commit_cnt = '0;
        for (int p = 0; p < `LDU_NUM; p++) begin
            i_ld_wr[p] = '0;
        end
        for (int s = 0; s < `STU_NUM; s++) begin
            i_st_chk[s] = '0;
        end
        rng     = 32'd73603;
        rob_ctr = '0;
        clear_model();
        clear_stim();
        repeat (RESET_CYCLES) @(posedge clk);
        i_rst <= 1'b0;

        // empty queue after reset
        step();
        stage_store(0, 6'h01, 32'h0000_1000, 8'hff);
        stage_store(1, 6'h01, 32'h0000_2000, 8'hff);
        step();

        // one load per port, then an older store to the same word
        stage_load(0, 0, 6'h05, 32'h0000_1000, 8'h0f, 6'h03, 32'h8000_0010);
        step();
        stage_store(0, 6'h02, 32'h0000_1004, 8'h0c);
        step();
        stage_load(1, 1, 6'h05, 32'h0000_2000, 8'hf0, 6'h04, 32'h8000_0014);
        step();
        stage_store(1, 6'h01, 32'h0000_2000, 8'h80);
        step();

        // younger store, other word, disjoint bytes, store snapshot past a wrap
        stage_store(0, 6'h06, 32'h0000_1000, 8'hff);
        stage_store(1, 6'h01, 32'h0000_1008, 8'hff);
        step();
        stage_store(0, 6'h01, 32'h0000_1000, 8'hf0);
        stage_store(1, 6'h22, 32'h0000_1000, 8'h0f);
        step();

        fl = 1'b1;
        step();
        stage_store(0, 6'h01, 32'h0000_1000, 8'h0f);
        step();

        // several matches with rob ages on both sides of a wrap
        stage_load(0, 2, 6'h08, 32'h0000_3000, 8'h03, 6'h21, 32'h8000_0020);
        stage_load(1, 3, 6'h08, 32'h0000_3000, 8'h01, 6'h1e, 32'h8000_0024);
        step();
        stage_load(0, 4, 6'h08, 32'h0000_3000, 8'h02, 6'h20, 32'h8000_0028);
        step();
        stage_store(0, 6'h03, 32'h0000_3000, 8'h03);
        stage_store(1, 6'h03, 32'h0000_3004, 8'h02);
        step();

        // load and check land together
        stage_load(0, 5, 6'h09, 32'h0000_5000, 8'h10, 6'h22, 32'h8000_0030);
        stage_store(1, 6'h04, 32'h0000_5000, 8'h30);
        step();
        fl = 1'b1;
        step();

        // in-order allocation at the tail, random commits and checks
        for (int c = 0; c < RAND_CYCLES; c++) begin
            rng = xorshift(rng);
            if (rng[31:27] == 5'd0) begin
                fl = 1'b1;
            end else begin
                cmt = int'(rng[1:0]) % 3;
                if (cmt > mdl_cnt) begin
                    cmt = mdl_cnt;
                end
                nwr = int'(rng[3:2]) % 3;
                if (mdl_cnt + nwr > `LQ_DEPTH) begin
                    nwr = `LQ_DEPTH - mdl_cnt;
                end
                for (int p = 0; p < nwr; p++) begin
                    rng = xorshift(rng);
                    stage_load(p, (mdl_deq + mdl_cnt + p) % `LQ_DEPTH, rng[5:0],
                               {24'h000040, 3'b000, rng[7:6], rng[10:8]}, rng[18:11],
                               rob_ctr, xorshift(rng));
                    rob_ctr = rob_ctr + 6'd1;
                end
                for (int s = 0; s < `STU_NUM; s++) begin
                    rng = xorshift(rng);
                    if (rng[0]) begin
                        stage_store(s, rng[6:1], {24'h000040, 3'b000, rng[8:7], 3'b000},
                                    rng[16:9]);
                    end
                end
            end
            step();
        end

        // last pending compare
        step();
        $display("STATUS: PASS");
        $finish;
    end

endmodule

//--- all.f
+incdir+common
common/lsq_pkg.sv
rtl/oldest_select.sv
load_queue/lq_ctrl.sv
load_queue/lq_entry_array.sv
load_queue/lq_vio_check.sv
rtl/lsq_top.sv
bench/lsq_properties.sv
bench/lsq_tb.sv

//--- Makefile
TOP = lsq_tb
SIM = obj_dir/V$(TOP)

.PHONY: run clean

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "^STATUS: PASS$$" sim.log

$(SIM): all.f $(wildcard common/*.sv common/*.svh load_queue/*.sv rtl/*.sv bench/*.sv)
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f all.f

clean:
	rm -rf obj_dir sim.log
